// File: include/decode_defines.svh
`default_nettype none
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// field window handed from the classifier to the separator
`define DISP_IMM_BITS 64
`define IMM_BITS 48
`define DISP_BITS 32

// instruction bytes on the input, byte 0 is the opcode
`define INSN_BYTES 10

// byte counts and instruction length
`define BYTE_CNT_BITS 4

`endif
`default_nettype wire

// File: design/x86_field_pkg.sv
`default_nettype none

package x86_field_pkg;

   // decoded opcode class
   typedef enum logic [2:0] {
      OPC_ALU_RM      = 3'd0,
      OPC_ALU_IMM     = 3'd1,
      OPC_MOV_IMM     = 3'd2,
      OPC_JMP_REL     = 3'd3,
      OPC_JMP_FAR     = 3'd4,
      OPC_UNSUPPORTED = 3'd5
   } opc_class_e;

   // operand size, value is the byte count
   typedef enum logic [2:0] {
      SIZE_BYTE  = 3'd1,
      SIZE_WORD  = 3'd2,
      SIZE_DWORD = 3'd4
   } size_e;

   // supported one-byte opcodes
   typedef enum logic [7:0] {
      OP_ADD_EB_GB  = 8'h00,
      OP_ADD_EV_GV  = 8'h01,
      OP_ADD_GB_EB  = 8'h02,
      OP_ADD_GV_EV  = 8'h03,
      OP_GRP1_EB_IB = 8'h80,
      OP_GRP1_EV_IV = 8'h81,
      OP_GRP1_EV_IB = 8'h83,
      OP_MOV_RB_IB  = 8'hB0,
      OP_MOV_RV_IV  = 8'hB8,
      OP_MOV_EB_IB  = 8'hC6,
      OP_MOV_EV_IV  = 8'hC7,
      OP_JMP_REL32  = 8'hE9,
      OP_JMP_FAR    = 8'hEA,
      OP_JMP_REL8   = 8'hEB
   } opcode_e;

   typedef struct packed {
      logic [1:0] mode;
      logic [2:0] reg_op;
      logic [2:0] rm;
   } modrm_t;

endpackage

`default_nettype wire

// File: design/decode_ctrl_pkg.sv
`default_nettype none

package decode_ctrl_pkg;

   // occupancy of the single decode stage
   typedef enum logic {
      ST_EMPTY = 1'b0,
      ST_FULL  = 1'b1
   } stage_state_e;

endpackage

`default_nettype wire

// File: design/field_info_if.sv
`timescale 1ns/100ps
`include "decode_defines.svh"
`default_nettype none

// field layout from the classifier to the separator, purely combinational
interface field_info_if
   import x86_field_pkg::*;
();

   // byte after the opcode or ModRM sits in the top byte
   logic [`DISP_IMM_BITS-1:0] window;
   logic [`BYTE_CNT_BITS-1:0] imm_bytes;
   logic [`BYTE_CNT_BITS-1:0] disp_bytes;
   size_e                     size;

   modport source (
      output window,
      output imm_bytes,
      output disp_bytes,
      output size
   );

   modport sink (
      input window,
      input imm_bytes,
      input disp_bytes,
      input size
   );

endinterface

`default_nettype wire

// File: design/byte_shifter_right.sv
`timescale 1ns/100ps
`default_nettype none

// right shift by whole bytes, vacated upper bytes read as zero
module byte_shifter_right #(
   parameter int BYTES = 8
) (
   input  wire logic [BYTES*8-1:0] in,
   input  wire logic [2:0]         amount,
   output logic [BYTES*8-1:0]      out
);

   always_comb begin
      out = '0;
      for (int i = 0; i < BYTES; i++) begin
         // output byte i takes input byte i + amount when it exists
         for (int j = i; j < BYTES; j++) begin
            if (j - i == int'(amount)) begin
               out[8*i +: 8] = in[8*j +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: design/opcode_classifier.sv
`timescale 1ns/100ps
`include "decode_defines.svh"
`default_nettype none

module opcode_classifier
   import x86_field_pkg::*;
(
   input  wire logic [`INSN_BYTES*8-1:0] insn_bytes,
   input  wire logic                     opsize_ovr,
   field_info_if.source                  info,
   output opc_class_e                    opc_class,
   output logic [`BYTE_CNT_BITS-1:0]     length
);

   localparam int CW        = `BYTE_CNT_BITS;
   localparam int WIN_BYTES = `DISP_IMM_BITS / 8;

   logic [7:0]                opcode;
   modrm_t                    modrm;
   logic                      has_modrm;
   logic                      need_sib;
   logic                      supported;
   logic [CW-1:0]             disp_len;
   logic [CW-1:0]             imm_len;
   logic [CW-1:0]             full_imm_len;
   opc_class_e                op_class;
   size_e                     op_size;
   size_e                     dflt_size;
   logic [`DISP_IMM_BITS-1:0] field_win;

   assign opcode = insn_bytes[7:0];
   assign modrm  = modrm_t'(insn_bytes[15:8]);

   // 32-bit default, override drops to 16
   assign dflt_size    = opsize_ovr ? SIZE_WORD : SIZE_DWORD;
   assign full_imm_len = opsize_ovr ? CW'(2) : CW'(4);

   always_comb begin
      op_class  = OPC_UNSUPPORTED;
      op_size   = dflt_size;
      has_modrm = 1'b0;
      imm_len   = '0;
      case (opcode)
         OP_ADD_EB_GB, OP_ADD_GB_EB: begin
            op_class  = OPC_ALU_RM;
            op_size   = SIZE_BYTE;
            has_modrm = 1'b1;
         end
         OP_ADD_EV_GV, OP_ADD_GV_EV: begin
            op_class  = OPC_ALU_RM;
            has_modrm = 1'b1;
         end
         OP_GRP1_EB_IB, OP_MOV_EB_IB: begin
            op_class  = (opcode == OP_MOV_EB_IB) ? OPC_MOV_IMM : OPC_ALU_IMM;
            op_size   = SIZE_BYTE;
            has_modrm = 1'b1;
            imm_len   = CW'(1);
         end
         OP_GRP1_EV_IV, OP_MOV_EV_IV: begin
            op_class  = (opcode == OP_MOV_EV_IV) ? OPC_MOV_IMM : OPC_ALU_IMM;
            has_modrm = 1'b1;
            imm_len   = full_imm_len;
         end
         OP_GRP1_EV_IB: begin
            // ib gets sign-extended to the operand size
            op_class  = OPC_ALU_IMM;
            has_modrm = 1'b1;
            imm_len   = CW'(1);
         end
         OP_JMP_REL32: begin
            op_class = OPC_JMP_REL;
            imm_len  = full_imm_len;
         end
         OP_JMP_REL8: begin
            op_class = OPC_JMP_REL;
            op_size  = SIZE_DWORD;
            imm_len  = CW'(1);
         end
         OP_JMP_FAR: begin
            // offset plus 16-bit selector
            op_class = OPC_JMP_FAR;
            imm_len  = full_imm_len + CW'(2);
         end
         default: begin
            // mov reg, imm with the register in the low 3 bits
            if ({opcode[7:3], 3'b000} == OP_MOV_RB_IB) begin
               op_class = OPC_MOV_IMM;
               op_size  = SIZE_BYTE;
               imm_len  = CW'(1);
            end else if ({opcode[7:3], 3'b000} == OP_MOV_RV_IV) begin
               op_class = OPC_MOV_IMM;
               imm_len  = full_imm_len;
            end
         end
      endcase
   end

   // displacement length, 32-bit addressing only
   always_comb begin
      disp_len = '0;
      if (has_modrm) begin
         case (modrm.mode)
            2'b01:   disp_len = CW'(1);
            2'b10:   disp_len = CW'(4);
            2'b00:   disp_len = (modrm.rm == 3'b101) ? CW'(4) : CW'(0);
            default: disp_len = '0;
         endcase
      end
   end

   // memory form with rm 100 needs a SIB byte
   assign need_sib  = has_modrm && (modrm.mode != 2'b11) && (modrm.rm == 3'b100);
   assign supported = (op_class != OPC_UNSUPPORTED) && !need_sib;

   // top-aligned window starting after the opcode or ModRM
   always_comb begin
      for (int k = 0; k < WIN_BYTES; k++) begin
         field_win[`DISP_IMM_BITS-1-8*k -: 8] = has_modrm ? insn_bytes[8*(k+2) +: 8]
                                                          : insn_bytes[8*(k+1) +: 8];
      end
   end

   assign opc_class       = supported ? op_class : OPC_UNSUPPORTED;
   assign info.size       = op_size;
   assign info.window     = supported ? field_win : '0;
   assign info.imm_bytes  = supported ? imm_len : '0;
   assign info.disp_bytes = supported ? disp_len : '0;

   assign length = supported ? CW'(1) + CW'(has_modrm) + disp_len + imm_len : CW'(1);

endmodule

`default_nettype wire

// File: design/imm_disp_separate.sv
`timescale 1ns/100ps
`include "decode_defines.svh"
`default_nettype none

module imm_disp_separate
   import x86_field_pkg::*;
(
   field_info_if.sink           info,
   output logic [`IMM_BITS-1:0]  dec_imm,
   output logic [`DISP_BITS-1:0] dec_disp
);

   localparam int WIN_BYTES  = `DISP_IMM_BITS / 8;
   localparam int IMM_BYTES  = `IMM_BITS / 8;
   localparam int DISP_BYTES = `DISP_BITS / 8;

   logic [`DISP_IMM_BITS-1:0] swapped;
   logic [`DISP_IMM_BITS-1:0] imm_shifted;
   logic [`IMM_BITS-1:0]      imm_mask;
   logic [`IMM_BITS-1:0]      imm_ext;
   logic [`DISP_BITS-1:0]     disp_mask;
   logic [`DISP_BITS-1:0]     disp_masked;
   logic [`DISP_BITS-1:0]     disp_ext;
   logic [2:0]                imm_mask_amt;
   logic [2:0]                disp_mask_amt;
   logic                      imm_one;
   logic                      disp_one;
   logic                      disp_none;

   // little-endian view, first field byte in bits 7:0
   always_comb begin
      for (int k = 0; k < WIN_BYTES; k++) begin
         swapped[8*k +: 8] = info.window[`DISP_IMM_BITS-1-8*k -: 8];
      end
   end

   assign imm_mask_amt  = 3'(IMM_BYTES - int'(info.imm_bytes));
   assign disp_mask_amt = 3'(DISP_BYTES - int'(info.disp_bytes));

   // immediate starts right after the displacement
   byte_shifter_right #(.BYTES(WIN_BYTES)) u_imm_shift (
      .in     (swapped),
      .amount (info.disp_bytes[2:0]),
      .out    (imm_shifted)
   );

   byte_shifter_right #(.BYTES(IMM_BYTES)) u_imm_mask (
      .in     ({`IMM_BITS{1'b1}}),
      .amount (imm_mask_amt),
      .out    (imm_mask)
   );

   byte_shifter_right #(.BYTES(DISP_BYTES)) u_disp_mask (
      .in     ({`DISP_BITS{1'b1}}),
      .amount (disp_mask_amt),
      .out    (disp_mask)
   );

   assign imm_one   = (info.imm_bytes == `BYTE_CNT_BITS'(1));
   assign disp_one  = (info.disp_bytes == `BYTE_CNT_BITS'(1));
   assign disp_none = (info.disp_bytes == '0);

   // disp8 always widens to 32 bits
   assign disp_ext = disp_one ? {{(`DISP_BITS-8){swapped[7]}}, 8'h00} : '0;

   // one-byte immediate widens to the operand size
   always_comb begin
      imm_ext = '0;
      if (imm_one) begin
         case (info.size)
            SIZE_DWORD: imm_ext = {{(`IMM_BITS-32){1'b0}}, {24{imm_shifted[7]}}, 8'h00};
            SIZE_WORD:  imm_ext = {{(`IMM_BITS-16){1'b0}}, {8{imm_shifted[7]}}, 8'h00};
            default:    imm_ext = '0;
         endcase
      end
   end

   assign disp_masked = swapped[`DISP_BITS-1:0] & disp_mask;

   assign dec_imm  = (imm_shifted[`IMM_BITS-1:0] & imm_mask) | imm_ext;
   assign dec_disp = disp_none ? '0 : (disp_masked | disp_ext);

endmodule

`default_nettype wire

// File: design/decode_pipe.sv
`timescale 1ns/100ps
`include "decode_defines.svh"
`default_nettype none

module decode_pipe
   import x86_field_pkg::*;
   import decode_ctrl_pkg::*;
(
   input  wire logic                      clk,
   input  wire logic                      arst_n,
   input  wire logic                      in_valid,
   input  wire logic                      stall,
   input  wire opc_class_e                in_class,
   input  wire size_e                     in_size,
   input  wire logic [`BYTE_CNT_BITS-1:0] in_length,
   input  wire logic [`IMM_BITS-1:0]      in_imm,
   input  wire logic [`DISP_BITS-1:0]     in_disp,
   output logic                           dec_valid,
   output opc_class_e                     dec_class,
   output size_e                          dec_size,
   output logic [`BYTE_CNT_BITS-1:0]      dec_length,
   output logic [`IMM_BITS-1:0]           dec_imm,
   output logic [`DISP_BITS-1:0]          dec_disp
);

   stage_state_e state_q;

   // stall freezes the stage, otherwise follow in_valid
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ST_EMPTY;
      end else if (!stall) begin
         state_q <= in_valid ? ST_FULL : ST_EMPTY;
      end
   end

   // outputs read as zero straight out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec_class  <= opc_class_e'(3'd0);
         dec_size   <= size_e'(3'd0);
         dec_length <= '0;
         dec_imm    <= '0;
         dec_disp   <= '0;
      end else if (in_valid && !stall) begin
         dec_class  <= in_class;
         dec_size   <= in_size;
         dec_length <= in_length;
         dec_imm    <= in_imm;
         dec_disp   <= in_disp;
      end
   end

   assign dec_valid = (state_q == ST_FULL);

endmodule

`default_nettype wire

// File: design/x86_decode_s0_top.sv
`timescale 1ns/100ps
`include "decode_defines.svh"
`default_nettype none

module x86_decode_s0_top
   import x86_field_pkg::*;
(
   input  wire logic                      clk,
   input  wire logic                      arst_n,
   input  wire logic                      insn_valid,
   input  wire logic [`INSN_BYTES*8-1:0]  insn_bytes,
   input  wire logic                      opsize_ovr,
   input  wire logic                      stall,
   output logic                           dec_valid,
   output opc_class_e                     dec_class,
   output size_e                          dec_size,
   output logic [`BYTE_CNT_BITS-1:0]      dec_length,
   output logic [`IMM_BITS-1:0]           dec_imm,
   output logic [`DISP_BITS-1:0]          dec_disp
);

   opc_class_e                cls_class;
   logic [`BYTE_CNT_BITS-1:0] cls_length;
   logic [`IMM_BITS-1:0]      sep_imm;
   logic [`DISP_BITS-1:0]     sep_disp;

   field_info_if field_info ();

   opcode_classifier u_classifier (
      .insn_bytes (insn_bytes),
      .opsize_ovr (opsize_ovr),
      .info       (field_info.source),
      .opc_class  (cls_class),
      .length     (cls_length)
   );

   imm_disp_separate u_separate (
      .info     (field_info.sink),
      .dec_imm  (sep_imm),
      .dec_disp (sep_disp)
   );

   decode_pipe u_pipe (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (insn_valid),
      .stall      (stall),
      .in_class   (cls_class),
      .in_size    (field_info.size),
      .in_length  (cls_length),
      .in_imm     (sep_imm),
      .in_disp    (sep_disp),
      .dec_valid  (dec_valid),
      .dec_class  (dec_class),
      .dec_size   (dec_size),
      .dec_length (dec_length),
      .dec_imm    (dec_imm),
      .dec_disp   (dec_disp)
   );

endmodule

`default_nettype wire

// File: test/decode_properties.sv
`timescale 1ns/100ps
`include "decode_defines.svh"
`default_nettype none

module decode_properties
   import x86_field_pkg::*;
(
   input wire logic                      clk,
   input wire logic                      arst_n,
   input wire logic                      stall,
   input wire logic                      dec_valid,
   input wire opc_class_e                dec_class,
   input wire size_e                     dec_size,
   input wire logic [`BYTE_CNT_BITS-1:0] dec_length,
   input wire logic [`IMM_BITS-1:0]      dec_imm,
   input wire logic [`DISP_BITS-1:0]     dec_disp
);

   int unsigned fail_count = 0;

   // stage stays empty while reset is held
   a_empty_in_reset : assert property (@(posedge clk) !arst_n |-> !dec_valid)
      else begin
         $error("dec_valid high while arst_n is low");
         fail_count++;
      end

   // a stalled valid result is frozen for the next cycle
   a_stall_holds : assert property (@(posedge clk) disable iff (!arst_n)
      (stall && dec_valid) |=> ($stable(dec_valid) && $stable(dec_class) &&
         $stable(dec_size) && $stable(dec_length) && $stable(dec_imm) &&
         $stable(dec_disp)))
      else begin
         $error("decode outputs changed during a stall");
         fail_count++;
      end

   // every decoded instruction is at least its opcode byte
   a_length_nonzero : assert property (@(posedge clk) disable iff (!arst_n)
      dec_valid |-> (dec_length >= `BYTE_CNT_BITS'(1)))
      else begin
         $error("dec_length is zero with dec_valid high");
         fail_count++;
      end

endmodule

bind x86_decode_s0_top decode_properties u_props (
   .clk        (clk),
   .arst_n     (arst_n),
   .stall      (stall),
   .dec_valid  (dec_valid),
   .dec_class  (dec_class),
   .dec_size   (dec_size),
   .dec_length (dec_length),
   .dec_imm    (dec_imm),
   .dec_disp   (dec_disp)
);

`default_nettype wire

// File: test/decode_tb.sv
`timescale 1ns/100ps
`include "decode_defines.svh"
`default_nettype none

module decode_tb
   import x86_field_pkg::*;
();

   localparam int WAIT_LIMIT = 20;

   logic                      clk = 1'b0;
   logic                      arst_n;
   logic                      insn_valid;
   logic [`INSN_BYTES*8-1:0]  insn_bytes;
   logic                      opsize_ovr;
   logic                      stall;
   logic                      dec_valid;
   opc_class_e                dec_class;
   size_e                     dec_size;
   logic [`BYTE_CNT_BITS-1:0] dec_length;
   logic [`IMM_BITS-1:0]      dec_imm;
   logic [`DISP_BITS-1:0]     dec_disp;

   int unsigned  check_count   = 0;
   int unsigned  error_count   = 0;
   int unsigned  timeout_count = 0;
   logic [15:0]  lfsr_state    = 16'd9;

   x86_decode_s0_top DUT (
      .clk        (clk),
      .arst_n     (arst_n),
      .insn_valid (insn_valid),
      .insn_bytes (insn_bytes),
      .opsize_ovr (opsize_ovr),
      .stall      (stall),
      .dec_valid  (dec_valid),
      .dec_class  (dec_class),
      .dec_size   (dec_size),
      .dec_length (dec_length),
      .dec_imm    (dec_imm),
      .dec_disp   (dec_disp)
   );

   always #50 clk = ~clk;

   // 16-bit Galois LFSR, one step per random bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // literal written in reading order, opcode leftmost
   function automatic logic [79:0] in_order(input logic [79:0] be);
      logic [79:0] le;
      for (int k = 0; k < 10; k++) begin
         le[8*k +: 8] = be[79-8*k -: 8];
      end
      return le;
   endfunction

   function automatic logic [7:0] pick_opcode(input logic [3:0] idx, input logic [2:0] r);
      case (idx)
         4'd0, 4'd1, 4'd2, 4'd3: return {6'b0, idx[1:0]};
         4'd4:    return 8'h80;
         4'd5:    return 8'h81;
         4'd6:    return 8'h83;
         4'd7:    return 8'hC6;
         4'd8:    return 8'hC7;
         4'd9:    return 8'hE9;
         4'd10:   return 8'hEA;
         4'd11:   return 8'hEB;
         4'd12:   return {5'b10110, r};
         4'd13:   return {5'b10111, r};
         default: return 8'h83;
      endcase
   endfunction

   // expected decode from opcode, ModRM and override
   task automatic model_decode(input logic [79:0] insn, input logic ovr,
                               output opc_class_e cls, output size_e sz,
                               output logic [3:0] len, output logic [47:0] imm,
                               output logic [31:0] disp);
      logic [7:0] b [10];
      int         has_modrm;
      int         disp_n;
      int         imm_n;
      int         full_n;
      int         p;
      for (int k = 0; k < 10; k++) begin
         b[k] = insn[8*k +: 8];
      end
      full_n    = ovr ? 2 : 4;
      sz        = ovr ? SIZE_WORD : SIZE_DWORD;
      cls       = OPC_UNSUPPORTED;
      has_modrm = 0;
      imm_n     = 0;
      disp_n    = 0;
      casez (b[0])
         8'h00, 8'h02: begin
            cls       = OPC_ALU_RM;
            sz        = SIZE_BYTE;
            has_modrm = 1;
         end
         8'h01, 8'h03: begin
            cls       = OPC_ALU_RM;
            has_modrm = 1;
         end
         8'h80: begin
            cls       = OPC_ALU_IMM;
            sz        = SIZE_BYTE;
            has_modrm = 1;
            imm_n     = 1;
         end
         8'h81: begin
            cls       = OPC_ALU_IMM;
            has_modrm = 1;
            imm_n     = full_n;
         end
         8'h83: begin
            cls       = OPC_ALU_IMM;
            has_modrm = 1;
            imm_n     = 1;
         end
         8'hC6: begin
            cls       = OPC_MOV_IMM;
            sz        = SIZE_BYTE;
            has_modrm = 1;
            imm_n     = 1;
         end
         8'hC7: begin
            cls       = OPC_MOV_IMM;
            has_modrm = 1;
            imm_n     = full_n;
         end
         8'b1011_0???: begin
            cls   = OPC_MOV_IMM;
            sz    = SIZE_BYTE;
            imm_n = 1;
         end
         8'b1011_1???: begin
            cls   = OPC_MOV_IMM;
            imm_n = full_n;
         end
         8'hE9: begin
            cls   = OPC_JMP_REL;
            imm_n = full_n;
         end
         8'hEB: begin
            cls   = OPC_JMP_REL;
            sz    = SIZE_DWORD;
            imm_n = 1;
         end
         8'hEA: begin
            cls   = OPC_JMP_FAR;
            imm_n = full_n + 2;
         end
         default: cls = OPC_UNSUPPORTED;
      endcase
      if (has_modrm == 1) begin
         if (b[1][7:6] == 2'b01) disp_n = 1;
         else if (b[1][7:6] == 2'b10) disp_n = 4;
         else if (b[1][7:6] == 2'b00 && b[1][2:0] == 3'b101) disp_n = 4;
         // SIB would follow, not handled here
         if (b[1][7:6] != 2'b11 && b[1][2:0] == 3'b100) cls = OPC_UNSUPPORTED;
      end
      imm  = '0;
      disp = '0;
      len  = 4'd1;
      if (cls == OPC_UNSUPPORTED) return;
      p = 1 + has_modrm;
      for (int i = 0; i < disp_n; i++) disp[8*i +: 8] = b[p+i];
      if (disp_n == 1) disp[31:8] = {24{b[p][7]}};
      for (int i = 0; i < imm_n; i++) imm[8*i +: 8] = b[p+disp_n+i];
      if (imm_n == 1 && sz == SIZE_DWORD) imm[31:8] = {24{imm[7]}};
      if (imm_n == 1 && sz == SIZE_WORD) imm[15:8] = {8{imm[7]}};
      len = 4'(1 + has_modrm + disp_n + imm_n);
   endtask

   task automatic check_field(input string name, input logic [47:0] got,
                              input logic [47:0] exp);
      check_count++;
      assert (got === exp) else begin
         $display("FAILED %s: got %h expected %h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_against_model(input logic [79:0] insn, input logic ovr);
      opc_class_e  e_cls;
      size_e       e_size;
      logic [3:0]  e_len;
      logic [47:0] e_imm;
      logic [31:0] e_disp;
      model_decode(insn, ovr, e_cls, e_size, e_len, e_imm, e_disp);
      check_field("dec_class", dec_class, e_cls);
      check_field("dec_size", dec_size, e_size);
      check_field("dec_length", dec_length, e_len);
      check_field("dec_imm", dec_imm, e_imm);
      check_field("dec_disp", dec_disp, e_disp);
   endtask

   task automatic wait_valid(output logic ok);
      ok = 1'b0;
      for (int n = 0; n < WAIT_LIMIT && !ok; n++) begin
         @(posedge clk);
         #1;
         ok = dec_valid;
      end
      if (!ok) begin
         $display("timeout: dec_valid did not rise within %0d cycles", WAIT_LIMIT);
         timeout_count++;
      end
   endtask

   task automatic decode_one(input logic [79:0] insn, input logic ovr);
      logic ok;
      @(negedge clk);
      insn_valid = 1'b1;
      insn_bytes = insn;
      opsize_ovr = ovr;
      stall      = 1'b0;
      wait_valid(ok);
      if (ok) check_against_model(insn, ovr);
   endtask

   task automatic test_reset_state();
      check_field("dec_valid", dec_valid, 0);
      check_field("dec_class", dec_class, 0);
      check_field("dec_size", dec_size, 0);
      check_field("dec_length", dec_length, 0);
      check_field("dec_imm", dec_imm, 0);
      check_field("dec_disp", dec_disp, 0);
   endtask

   task automatic test_disp_forms();
      decode_one(in_order(80'h01C1_0000_0000_0000_0000), 1'b0);
      decode_one(in_order(80'h0100_0000_0000_0000_0000), 1'b0);
      decode_one(in_order(80'h0141_1200_0000_0000_0000), 1'b0);
      decode_one(in_order(80'h0141_8500_0000_0000_0000), 1'b0);
      check_field("dec_disp", dec_disp, 32'hFFFF_FF85);
      decode_one(in_order(80'h0183_7856_3412_0000_0000), 1'b0);
      check_field("dec_disp", dec_disp, 32'h1234_5678);
      decode_one(in_order(80'h0105_EFBE_ADDE_0000_0000), 1'b0);
      check_field("dec_length", dec_length, 6);
   endtask

   task automatic test_imm_forms();
      decode_one(in_order(80'h8045_F09C_0000_0000_0000), 1'b0);
      check_field("dec_imm", dec_imm, 48'h9C);
      decode_one(in_order(80'h8145_8044_3322_1100_0000), 1'b0);
      decode_one(in_order(80'h8145_8044_3322_1100_0000), 1'b1);
      decode_one(in_order(80'h8345_F8FE_0000_0000_0000), 1'b0);
      check_field("dec_imm", dec_imm, 48'hFFFF_FFFE);
      decode_one(in_order(80'h8345_F8FE_0000_0000_0000), 1'b1);
      check_field("dec_imm", dec_imm, 48'hFFFE);
   endtask

   task automatic test_jumps_and_unsupported();
      decode_one(in_order(80'hEA11_2233_4455_6600_0000), 1'b0);
      check_field("dec_imm", dec_imm, 48'h6655_4433_2211);
      decode_one(in_order(80'hEA11_2233_4455_6600_0000), 1'b1);
      decode_one(in_order(80'hEB80_0000_0000_0000_0000), 1'b1);
      check_field("dec_imm", dec_imm, 48'hFFFF_FF80);
      decode_one(in_order(80'hE978_5634_1200_0000_0000), 1'b0);
      decode_one(in_order(80'h0F05_1122_3344_5566_7788), 1'b0);
      check_field("dec_class", dec_class, OPC_UNSUPPORTED);
      decode_one(in_order(80'h0104_2411_2233_4455_6677), 1'b0);
      check_field("dec_length", dec_length, 1);
   endtask

   task automatic test_stall_hold();
      logic [79:0] insn_b;
      logic [90:0] held;
      logic        ok;
      insn_b = in_order(80'hE978_5634_1200_0000_0000);
      decode_one(in_order(80'h0141_1200_0000_0000_0000), 1'b0);
      held = {dec_valid, dec_class, dec_size, dec_length, dec_imm, dec_disp};
      @(negedge clk);
      stall      = 1'b1;
      insn_bytes = insn_b;
      repeat (4) begin
         @(posedge clk);
         #1;
         check_field("dec_valid", dec_valid, held[90]);
         check_field("dec_class", dec_class, held[89:87]);
         check_field("dec_size", dec_size, held[86:84]);
         check_field("dec_length", dec_length, held[83:80]);
         check_field("dec_imm", dec_imm, held[79:32]);
         check_field("dec_disp", dec_disp, held[31:0]);
      end
      @(negedge clk);
      stall = 1'b0;
      wait_valid(ok);
      if (ok) check_against_model(insn_b, 1'b0);
      // idle cycle empties the stage
      @(negedge clk);
      insn_valid = 1'b0;
      ok = 1'b0;
      for (int n = 0; n < WAIT_LIMIT && !ok; n++) begin
         @(posedge clk);
         #1;
         ok = !dec_valid;
      end
      if (!ok) begin
         $display("timeout: dec_valid did not fall after an idle cycle");
         timeout_count++;
      end
   endtask

   task automatic test_random(input int count);
      logic [71:0] tail;
      logic [7:0]  opc;
      logic        ovr;
      for (int i = 0; i < count; i++) begin
         opc  = pick_opcode(4'(take_bits(4)), 3'(take_bits(3)));
         tail = {24'(take_bits(24)), 24'(take_bits(24)), 24'(take_bits(24))};
         ovr  = 1'(take_bits(1));
         decode_one({tail, opc}, ovr);
      end
   endtask

   initial begin
      arst_n     = 1'b0;
      insn_valid = 1'b0;
      insn_bytes = '0;
      opsize_ovr = 1'b0;
      stall      = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(posedge clk);
      #1;
      test_reset_state();
      test_disp_forms();
      test_imm_forms();
      test_jumps_and_unsupported();
      test_stall_hold();
      test_random(200);
      $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
               check_count, error_count, timeout_count, DUT.u_props.fail_count);
      if (error_count == 0 && timeout_count == 0 && DUT.u_props.fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
design/x86_field_pkg.sv
design/decode_ctrl_pkg.sv
design/field_info_if.sv
design/byte_shifter_right.sv
design/opcode_classifier.sv
design/imm_disp_separate.sv
design/decode_pipe.sv
design/x86_decode_s0_top.sv
test/decode_properties.sv
test/decode_tb.sv
